/* bench/mem_asserts.sv */
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module mem_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input lc3b_pkg::lc3b_wb_req wb_req,
    input lc3b_pkg::lc3b_wb_rsp wb_rsp,
    input logic                 request_stall
);

    // A pending strobe keeps its address, direction, lanes and data.
    property stb_held_until_ack;
        @(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) &&
             $stable(wb_req.sel) && $stable(wb_req.dat_m));
    endproperty

    // ACK only ends a strobe that has been held for the full latency.
    property ack_needs_stb;
        @(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.stb && $past(wb_req.stb, `LC3B_MEM_LATENCY));
    endproperty

    // request_stall drops only in the final ACK cycle.
    property stall_ends_on_ack;
        @(posedge clk) disable iff (!rst_n)
        $fell(request_stall) |-> wb_rsp.ack;
    endproperty

    a_stb_held:  assert property (stb_held_until_ack) else $error("Strobe changed before ACK.");
    a_ack_stb:   assert property (ack_needs_stb) else $error("ACK without a held strobe.");
    a_stall_end: assert property (stall_ends_on_ack)
        else $error("request_stall dropped without an ACK.");

endmodule

bind stage_mem mem_asserts u_mem_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .request_stall (request_stall)
);

/* bench/mem_tb.sv */
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module mem_tb;

    localparam int MEM_BYTES   = `LC3B_LINE_COUNT * `LC3B_LINE_BYTES;
    localparam int STALL_LIMIT = 4 * `LC3B_MEM_LATENCY + 8;

    logic                       clk;
    logic                       rst_n;
    logic                       stall;
    lc3b_pkg::lc3b_control_word control;
    lc3b_pkg::lc3b_word         alu;
    lc3b_pkg::lc3b_word         ir;
    lc3b_pkg::lc3b_word         pcn;
    lc3b_pkg::lc3b_word         sr2;
    logic                       br_en;
    lc3b_pkg::lc3b_word         mdr;
    logic                       request_stall;

    logic [7:0]         shadow [MEM_BYTES];                 // Byte image of the data memory.
    lc3b_pkg::lc3b_word expect_q [$];
    lc3b_pkg::lc3b_cc   model_cc;
    logic               model_br;
    lc3b_pkg::lc3b_word mdr_addr;

    mem_subsystem_top DUT (.*);

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input lc3b_pkg::lc3b_word got,
                              input lc3b_pkg::lc3b_word exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Expected mdr of one operation; stores update the shadow memory.
    function automatic lc3b_pkg::lc3b_word ref_access(input lc3b_pkg::lc3b_mem_op op,
            input logic word_align, input lc3b_pkg::lc3b_word a_in,
            input lc3b_pkg::lc3b_word ir_v, input lc3b_pkg::lc3b_word data);
        logic [11:0] a;
        logic        whole;
        a = a_in[11:0];
        if (op == lc3b_pkg::MEM_TRAP) begin
            a = {3'b000, ir_v[7:0], 1'b0};
        end else if (op == lc3b_pkg::MEM_LDI || op == lc3b_pkg::MEM_STI) begin
            a = {shadow[{a[11:1], 1'b1}][3:0], shadow[{a[11:1], 1'b0}]};  // Pointer word.
        end
        whole = word_align || (op == lc3b_pkg::MEM_TRAP);
        if (op == lc3b_pkg::MEM_STORE || op == lc3b_pkg::MEM_STI) begin
            if (whole) begin
                shadow[{a[11:1], 1'b0}] = data[7:0];
                shadow[{a[11:1], 1'b1}] = data[15:8];
            end else begin
                shadow[a] = data[7:0];
            end
            return 16'h0000;
        end
        if (whole) begin
            return {shadow[{a[11:1], 1'b1}], shadow[{a[11:1], 1'b0}]};
        end
        return {8'h00, shadow[a]};
    endfunction

    function automatic lc3b_pkg::lc3b_cc sign_class(input lc3b_pkg::lc3b_word v);
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return v[15] ? 3'b100 : 3'b001;
    endfunction

    // Final ACK cycle of a load, TRAP or LDI.
    always @(posedge clk) begin
        if (rst_n && !request_stall && (control.mem_op == lc3b_pkg::MEM_LOAD ||
                control.mem_op == lc3b_pkg::MEM_LDI || control.mem_op == lc3b_pkg::MEM_TRAP)) begin
            if (expect_q.size() == 0) begin
                $display("A load completed but no expected result was queued.");
                abort_run();
            end else begin
                check_word("mdr", mdr, expect_q.pop_front());
            end
        end
    end

    task automatic run_op(input lc3b_pkg::lc3b_mem_op op, input logic word_align,
                          input lc3b_pkg::lc3b_word a, input lc3b_pkg::lc3b_word data,
                          input lc3b_pkg::lc3b_word ir_v, output int cycles);
        lc3b_pkg::lc3b_word exp;
        bit                 finished;
        @(negedge clk);
        control            = '0;
        control.mem_op     = op;
        control.word_align = word_align;
        alu = a;
        sr2 = data;
        ir  = ir_v;
        pcn = 16'($urandom);
        exp = ref_access(op, word_align, a, ir_v, data);
        if (op == lc3b_pkg::MEM_LOAD || op == lc3b_pkg::MEM_LDI || op == lc3b_pkg::MEM_TRAP) begin
            expect_q.push_back(exp);
        end
        cycles   = 0;
        finished = 0;
        while (!finished) begin
            @(posedge clk);
            if (!request_stall) begin
                finished = 1;
            end else begin
                cycles++;
                if (cycles > STALL_LIMIT) begin
                    $display("Timeout: request_stall stayed high for %0d cycles.", cycles);
                    abort_run();
                end
            end
        end
        @(negedge clk);
        control = '0;                                       // One idle cycle between operations.
    endtask

    // One cc_load cycle, then one br_en_load cycle, optionally under stall.
    task automatic cc_step(input int sel, input lc3b_pkg::lc3b_word v,
                           input lc3b_pkg::lc3b_cc nzp, input logic hold, input logic load_cc);
        lc3b_pkg::lc3b_word src;
        @(negedge clk);
        stall              = hold;
        control            = '0;
        control.cc_sel     = lc3b_pkg::lc3b_cc_sel'(sel[1:0]);
        control.cc_load    = load_cc;
        control.word_align = 1'b1;
        pcn = 16'($urandom);
        alu = 16'($urandom);
        sr2 = 16'($urandom);
        src = v;
        case (sel)
            0: pcn = v;
            1: alu = v;
            2: begin
                alu = mdr_addr;                             // mdr shows the word at alu.
                src = ref_access(lc3b_pkg::MEM_LOAD, 1'b1, mdr_addr, 16'h0000, 16'h0000);
            end
            default: sr2 = v;
        endcase
        if (!hold && load_cc) begin
            model_cc = sign_class(src);
        end
        @(negedge clk);
        control.cc_load    = 1'b0;
        control.br_en_load = 1'b1;
        ir = {4'h0, nzp, 9'h000};
        if (!hold) begin
            model_br = (nzp[2] && model_cc == 3'b100) || (nzp[1] && model_cc == 3'b010) ||
                       (nzp[0] && model_cc == 3'b001);
        end
        @(negedge clk);
        control = '0;
        stall   = 1'b0;
        check_bit("br_en", br_en, model_br);
    endtask

    initial begin
        int                 n_cycles;
        int                 load_cycles;
        int                 ldi_cycles;
        lc3b_pkg::lc3b_word addrs [8];
        lc3b_pkg::lc3b_word a;
        lc3b_pkg::lc3b_word p;
        lc3b_pkg::lc3b_word ir_v;
        void'($urandom(32'h8113));
        clk      = 1'b0;
        rst_n    = 1'b0;
        stall    = 1'b0;
        control  = '0;
        alu      = '0;
        ir       = '0;
        pcn      = '0;
        sr2      = '0;
        model_cc = '0;
        model_br = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("request_stall after reset", request_stall, 1'b0);
        check_bit("br_en after reset", br_en, 1'b0);

        // cc starts cleared, so no branch condition can match.
        cc_step(0, 16'h0001, 3'b111, 1'b0, 1'b0);

        // Words at random even addresses; upper address bits alias.
        for (int i = 0; i < 8; i++) begin
            addrs[i] = 16'($urandom) & 16'hFFFE;
            run_op(lc3b_pkg::MEM_STORE, 1'b1, addrs[i], 16'($urandom), 16'h0000, n_cycles);
        end
        for (int i = 0; i < 8; i++) begin
            run_op(lc3b_pkg::MEM_LOAD, 1'b1, addrs[i], 16'($urandom), 16'h0000, n_cycles);
        end

        // Byte store into a known word, then byte and word read back.
        for (int i = 0; i < 6; i++) begin
            a = (16'($urandom) & 16'hFFFE) | 16'(i % 2);
            run_op(lc3b_pkg::MEM_STORE, 1'b1, a & 16'hFFFE, 16'($urandom), 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_STORE, 1'b0, a, 16'($urandom), 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_LOAD, 1'b0, a, 16'($urandom), 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_LOAD, 1'b1, a & 16'hFFFE, 16'($urandom), 16'h0000, n_cycles);
        end

        // Pointer at a, target at p in another line.
        for (int i = 0; i < 4; i++) begin
            a = 16'($urandom) & 16'hFFFE;
            p = (a ^ 16'h0810) | 16'(i % 2);
            run_op(lc3b_pkg::MEM_STORE, 1'b1, a, p, 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_STORE, 1'b1, p & 16'hFFFE, 16'($urandom), 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_LOAD, i % 2 == 0, p, 16'($urandom), 16'h0000, load_cycles);
            run_op(lc3b_pkg::MEM_LDI, i % 2 == 0, a, 16'($urandom), 16'h0000, ldi_cycles);
            check_bit("LDI stall longer than LOAD", ldi_cycles > load_cycles, 1'b1);
            run_op(lc3b_pkg::MEM_STI, i % 2 == 0, a, 16'($urandom), 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_LOAD, 1'b1, p & 16'hFFFE, 16'($urandom), 16'h0000, n_cycles);
        end

        // TRAP reads a whole word even with word_align low.
        for (int i = 0; i < 4; i++) begin
            ir_v     = 16'($urandom);
            mdr_addr = {7'b0, ir_v[7:0], 1'b0};
            run_op(lc3b_pkg::MEM_STORE, 1'b1, mdr_addr, 16'($urandom), 16'h0000, n_cycles);
            run_op(lc3b_pkg::MEM_TRAP, 1'b0, 16'($urandom), 16'($urandom), ir_v, n_cycles);
        end

        for (int r = 0; r < 3; r++) begin
            for (int s = 0; s < 4; s++) begin
                a = ($urandom % 4 == 0) ? 16'h0000 : 16'($urandom);
                cc_step(s, a, 3'($urandom), 1'b0, 1'b1);
            end
        end

        // Stall hold: br_en stays 0 and cc keeps the positive class.
        cc_step(1, 16'h0005, 3'b000, 1'b0, 1'b1);
        cc_step(1, 16'h8000, 3'b111, 1'b1, 1'b1);
        cc_step(1, 16'h0000, 3'b001, 1'b0, 1'b0);
        cc_step(1, 16'h0000, 3'b110, 1'b0, 1'b0);

        if (expect_q.size() != 0) begin
            $display("%0d expected load results were never compared.", expect_q.size());
            $display("Finished with errors");
            $fatal(1);
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+rtl
rtl/lc3b_pkg.sv
rtl/cc_unit.sv
rtl/mem_access_controller.sv
rtl/stage_mem.sv
rtl/line_memory.sv
rtl/mem_subsystem_top.sv
bench/mem_asserts.sv
bench/mem_tb.sv

/* rtl/cc_unit.sv */
`timescale 1ns/1ps

module cc_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  lc3b_pkg::lc3b_cc_sel cc_sel,
    input  logic                 cc_load,
    input  logic                 br_en_load,
    input  lc3b_pkg::lc3b_word   pcn,
    input  lc3b_pkg::lc3b_word   alu,
    input  lc3b_pkg::lc3b_word   mdr,
    input  lc3b_pkg::lc3b_word   sr2,
    input  lc3b_pkg::lc3b_cc     nzp,
    output logic                 br_en
);

    lc3b_pkg::lc3b_word cc_src;
    lc3b_pkg::lc3b_cc   cc_gen;
    lc3b_pkg::lc3b_cc   cc;

    always_comb begin
        case (cc_sel)
            lc3b_pkg::CC_SEL_PCN: cc_src = pcn;
            lc3b_pkg::CC_SEL_ALU: cc_src = alu;
            lc3b_pkg::CC_SEL_MDR: cc_src = mdr;
            default:              cc_src = sr2;
        endcase
    end

    // Signed sign class of the selected value.
    assign cc_gen[2] = cc_src[15];
    assign cc_gen[1] = (cc_src == 16'h0000);
    assign cc_gen[0] = !cc_src[15] && (cc_src != 16'h0000);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc    <= '0;
            br_en <= 1'b0;
        end else if (!stall) begin
            if (cc_load) begin
                cc <= cc_gen;
            end
            if (br_en_load) begin
                br_en <= |(cc & nzp);                       // Uses the stored codes.
            end
        end
    end

endmodule

/* rtl/lc3b_consts.svh */
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// Data memory geometry.
// The line index is taken from the low bits of the bus address.
`define LC3B_LINE_COUNT 256

// Bytes held in one memory line.
`define LC3B_LINE_BYTES 16

// Cycles from the start of a strobe to its acknowledge.
`define LC3B_MEM_LATENCY 2

// Width of the line address carried on the bus.
`define LC3B_ADR_WIDTH 12

`endif

/* rtl/lc3b_pkg.sv */
`include "lc3b_consts.svh"

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_cc;                           // Ordered n, z, p.
    typedef logic [`LC3B_LINE_BYTES*8-1:0] lc3b_line;

    // Memory operation of the instruction in the stage.
    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_LDI,
        MEM_STI,
        MEM_TRAP
    } lc3b_mem_op;

    // Source of the value that sets the condition codes.
    typedef enum logic [1:0] {
        CC_SEL_PCN,
        CC_SEL_ALU,
        CC_SEL_MDR,
        CC_SEL_SR2
    } lc3b_cc_sel;

    typedef enum logic [1:0] {
        ADDR_TRAPVECT8,
        ADDR_ALU,
        ADDR_MDR                                            // Pointer from the first access.
    } lc3b_addr_sel;

    typedef enum logic [1:0] {
        MACC_IDLE,
        MACC_FIRST,
        MACC_SECOND
    } lc3b_macc_state;

    typedef struct packed {
        lc3b_mem_op mem_op;
        lc3b_cc_sel cc_sel;
        logic       cc_load;
        logic       br_en_load;
        logic       word_align;                             // 1 for words, 0 for bytes.
    } lc3b_control_word;

    // Line-wide bus, master side.
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`LC3B_LINE_BYTES-1:0] sel;
        logic [`LC3B_ADR_WIDTH-1:0]  adr;
        lc3b_line                    dat_m;
    } lc3b_wb_req;

    typedef struct packed {
        logic     ack;
        lc3b_line dat_s;
    } lc3b_wb_rsp;

endpackage

/* rtl/line_memory.sv */
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module line_memory (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_pkg::lc3b_wb_req wb_req,
    output lc3b_pkg::lc3b_wb_rsp wb_rsp
);

    localparam int CNT_W = $clog2(`LC3B_MEM_LATENCY + 1);
    localparam int IDX_W = $clog2(`LC3B_LINE_COUNT);

    lc3b_pkg::lc3b_line mem [`LC3B_LINE_COUNT];
    logic [CNT_W-1:0]   wait_cnt;
    logic [IDX_W-1:0]   index;
    logic               strobe;
    logic               ack;

    assign strobe = wb_req.cyc && wb_req.stb;
    assign index  = wb_req.adr[IDX_W-1:0];                  // Upper address bits ignored.
    assign ack    = strobe && (wait_cnt == CNT_W'(`LC3B_MEM_LATENCY));

    // Counts cycles since the strobe started; restarts after each ACK.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!strobe || ack) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Byte-selected write at the end of the ACK cycle.
    always_ff @(posedge clk) begin
        if (ack && wb_req.we) begin
            for (int i = 0; i < `LC3B_LINE_BYTES; i++) begin
                if (wb_req.sel[i]) begin
                    mem[index][i*8 +: 8] <= wb_req.dat_m[i*8 +: 8];
                end
            end
        end
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_s = mem[index];                       // Whole line returned.

endmodule

/* rtl/mem_access_controller.sv */
`timescale 1ns/1ps

module mem_access_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  lc3b_pkg::lc3b_mem_op   mem_op,
    input  logic                   ack,
    output logic                   access,
    output logic                   write_en,
    output lc3b_pkg::lc3b_addr_sel addr_sel,
    output logic                   mdr_load,
    output logic                   request_stall
);

    lc3b_pkg::lc3b_macc_state state;
    lc3b_pkg::lc3b_macc_state state_next;
    logic indirect;
    logic second;
    logic done;
    logic final_step;

    assign indirect   = (mem_op == lc3b_pkg::MEM_LDI) || (mem_op == lc3b_pkg::MEM_STI);
    assign second     = (state == lc3b_pkg::MACC_SECOND);
    assign access     = (mem_op != lc3b_pkg::MEM_NONE);
    assign done       = access && ack && !stall;            // Current step completes.
    assign final_step = !indirect || second;

    // Pointer is captured on the first ACK of LDI and STI.
    assign mdr_load      = done && indirect && !second;
    assign request_stall = access && !(done && final_step);

    always_comb begin
        addr_sel = lc3b_pkg::ADDR_ALU;
        write_en = 1'b0;
        case (mem_op)
            lc3b_pkg::MEM_STORE: write_en = 1'b1;
            lc3b_pkg::MEM_TRAP:  addr_sel = lc3b_pkg::ADDR_TRAPVECT8;
            lc3b_pkg::MEM_LDI: begin
                if (second) begin
                    addr_sel = lc3b_pkg::ADDR_MDR;
                end
            end
            lc3b_pkg::MEM_STI: begin
                if (second) begin
                    addr_sel = lc3b_pkg::ADDR_MDR;
                    write_en = 1'b1;                        // Only the final access writes.
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        if (!access) begin
            state_next = lc3b_pkg::MACC_IDLE;
        end else if (second) begin
            if (done) begin
                state_next = lc3b_pkg::MACC_IDLE;
            end
        end else if (done) begin
            state_next = indirect ? lc3b_pkg::MACC_SECOND : lc3b_pkg::MACC_IDLE;
        end else begin
            state_next = lc3b_pkg::MACC_FIRST;              // First access still waiting.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lc3b_pkg::MACC_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* rtl/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  lc3b_pkg::lc3b_control_word control,
    input  lc3b_pkg::lc3b_word         alu,
    input  lc3b_pkg::lc3b_word         ir,
    input  lc3b_pkg::lc3b_word         pcn,
    input  lc3b_pkg::lc3b_word         sr2,
    output logic                       br_en,
    output lc3b_pkg::lc3b_word         mdr,
    output logic                       request_stall
);

    lc3b_pkg::lc3b_wb_req wb_req;
    lc3b_pkg::lc3b_wb_rsp wb_rsp;

    stage_mem u_stage_mem (
        .clk,
        .rst_n,
        .stall,
        .control,
        .alu,
        .ir,
        .pcn,
        .sr2,
        .wb_rsp,
        .wb_req,
        .br_en,
        .mdr,
        .request_stall
    );

    line_memory u_line_memory (
        .clk,
        .rst_n,
        .wb_req,
        .wb_rsp
    );

endmodule

/* rtl/stage_mem.sv */
`timescale 1ns/1ps

module stage_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  lc3b_pkg::lc3b_control_word control,
    input  lc3b_pkg::lc3b_word         alu,
    input  lc3b_pkg::lc3b_word         ir,
    input  lc3b_pkg::lc3b_word         pcn,
    input  lc3b_pkg::lc3b_word         sr2,
    input  lc3b_pkg::lc3b_wb_rsp       wb_rsp,
    output lc3b_pkg::lc3b_wb_req       wb_req,
    output logic                       br_en,
    output lc3b_pkg::lc3b_word         mdr,
    output logic                       request_stall
);

    lc3b_pkg::lc3b_addr_sel addr_sel;
    lc3b_pkg::lc3b_word     addr;
    lc3b_pkg::lc3b_word     trapvect8;
    lc3b_pkg::lc3b_word     internal_mdr;
    lc3b_pkg::lc3b_word     lane_data;
    logic                   access;
    logic                   write_en;
    logic                   mdr_load;
    logic                   pointer_read;
    logic                   word_access;
    logic [2:0]             lane;

    cc_unit u_cc_unit (
        .clk,
        .rst_n,
        .stall,
        .cc_sel     (control.cc_sel),
        .cc_load    (control.cc_load),
        .br_en_load (control.br_en_load),
        .pcn,
        .alu,
        .mdr,
        .sr2,
        .nzp        (ir[11:9]),
        .br_en
    );

    mem_access_controller u_mem_access_controller (
        .clk,
        .rst_n,
        .stall,
        .mem_op (control.mem_op),
        .ack    (wb_rsp.ack),
        .access,
        .write_en,
        .addr_sel,
        .mdr_load,
        .request_stall
    );

    assign trapvect8 = {7'b0, ir[7:0], 1'b0};

    always_comb begin
        case (addr_sel)
            lc3b_pkg::ADDR_TRAPVECT8: addr = trapvect8;
            lc3b_pkg::ADDR_MDR:       addr = internal_mdr;
            default:                  addr = alu;
        endcase
    end

    // Pointer reads and vector fetches are always whole words.
    assign pointer_read = (addr_sel == lc3b_pkg::ADDR_ALU) &&
                          ((control.mem_op == lc3b_pkg::MEM_LDI) ||
                           (control.mem_op == lc3b_pkg::MEM_STI));
    assign word_access  = control.word_align || pointer_read ||
                          (addr_sel == lc3b_pkg::ADDR_TRAPVECT8);

    assign lane = addr[3:1];                                // Word slot within the line.

    always_comb begin
        wb_req     = '0;
        wb_req.cyc = access;
        wb_req.stb = access;
        wb_req.we  = write_en;
        wb_req.adr = addr[15:4];
        if (word_access) begin
            wb_req.sel[lane*2 +: 2]    = 2'b11;
            wb_req.dat_m[lane*16 +: 16] = sr2;
        end else if (addr[0]) begin
            wb_req.sel[lane*2 +: 2]    = 2'b10;            // Odd address, high byte.
            wb_req.dat_m[lane*16 +: 16] = {sr2[7:0], 8'h00};
        end else begin
            wb_req.sel[lane*2 +: 2]    = 2'b01;
            wb_req.dat_m[lane*16 +: 16] = {8'h00, sr2[7:0]};
        end
    end

    // Load data is valid in the ACK cycle.
    assign lane_data = wb_rsp.dat_s[lane*16 +: 16];

    always_comb begin
        if (word_access) begin
            mdr = lane_data;
        end else if (addr[0]) begin
            mdr = {8'h00, lane_data[15:8]};
        end else begin
            mdr = {8'h00, lane_data[7:0]};                  // Zero-extended byte.
        end
    end

    // Holds the pointer between the two indirect accesses.
    always_ff @(posedge clk) begin
        if (mdr_load) begin
            internal_mdr <= mdr;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_tb -f files.f -Mdir obj_dir

./obj_dir/Vmem_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed."
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result."
    exit 1
fi
echo "Simulation passed."
